// File: Bender.yml
package:
  name: lma

export_include_dirs:
  - include

sources:
  - files:
      - rtl/lma_pkg.sv
      - rtl/lma_cmd_fifo.sv
      - rtl/lma_cell_alloc.sv
      - rtl/lma_self_test.sv
      - rtl/lma_top.sv
  - target: simulation
    files:
      - dv/lma_assertions.sv
      - dv/lma_tb.sv

// File: dv/lma_assertions.sv
/*
 * lma allocator checker
 * bound into the cell allocator, watches the command handshake,
 * response timing and the free-cell count range
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_assertions
    import lma_pkg::*;
(
    input logic                   i_clk,
    input logic                   i_rst_n,
    input logic                   i_cmd_valid,
    input lma_op_e                i_cmd_op,
    input logic [`LMA_WORD_W-1:0] i_cmd_word,
    input logic                   i_cmd_ready,
    input logic                   i_rsp_valid,
    input logic [`LMA_ADDR_W:0]   i_free_cnt
);

    // a stalled command keeps valid and payload until it is taken
    a_cmd_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd_valid && !i_cmd_ready)
            |=> (i_cmd_valid && $stable(i_cmd_op) && $stable(i_cmd_word))
    ) else $error("command payload changed while stalled");

    // alloc and read always answer on the next cycle
    a_rsp_next: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd_valid && i_cmd_ready && (i_cmd_op != OP_FREE)) |=> i_rsp_valid
    ) else $error("accepted alloc or read got no response on the next cycle");

    // free count bounded by the pool size
    a_free_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_free_cnt <= `LMA_CELLS
    ) else $error("free cell count above pool size");

endmodule

bind lma_cell_alloc lma_assertions u_assertions (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_op    (i_cmd_op),
    .i_cmd_word  (i_cmd_word),
    .i_cmd_ready (o_cmd_ready),
    .i_rsp_valid (o_rsp_valid),
    .i_free_cnt  (o_free_cnt)
);

// File: dv/lma_input.txt
# one run per line: length, pause flag, expected pass, expected count
# expected count is min(length, 16), pass only when length is at most 16
1 0 1 1
2 0 1 2
3 0 1 3
4 0 1 4
5 0 1 5
6 0 1 6
7 0 1 7
8 0 1 8
9 0 1 9
10 0 1 10
11 0 1 11
12 0 1 12
13 0 1 13
14 0 1 14
15 0 1 15
16 0 1 16
0 0 1 0
17 0 0 16
40 0 0 16
255 0 0 16
3 1 1 3
8 1 1 8
16 1 1 16
0 1 1 0
20 1 0 16
1 1 1 1
16 0 1 16

// File: dv/lma_tb.sv
/*
 * lma testbench
 * reads runs from the input data file and starts the self-test for each length,
 * optionally pausing i_en at random, then checks pass, count and the free pool
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_tb
    import lma_pkg::*;
();
    localparam int RUN_TIMEOUT  = 4000;
    localparam int POOL_TIMEOUT = 200;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_start;
    logic                  i_en;
    logic [`LMA_LEN_W-1:0] i_len;
    logic                  o_running;
    logic                  o_done;
    logic                  o_pass;
    logic [`LMA_LEN_W-1:0] o_count;
    logic [`LMA_ADDR_W:0]  o_free_cnt;

    int errors;
    int tests;
    int failed_tests;
    // set by a timeout, stops all further runs
    bit aborted;

    lma_top u_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_en       (i_en),
        .i_len      (i_len),
        .o_running  (o_running),
        .o_done     (o_done),
        .o_pass     (o_pass),
        .o_count    (o_count),
        .o_free_cnt (o_free_cnt)
    );

    // 40 ns period
    always #20 i_clk = ~i_clk;

    task automatic report_mismatch(input string name, input int exp_val, input int act_val);
        $display("** Error @ %0t ns: %s expected %0d, actual %0d", $time, name, exp_val, act_val);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("** Failure @ %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_sim();
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // covers the sweep after reset and the last FREEs draining after o_done
    task automatic wait_pool_full();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (o_free_cnt != `LMA_CELLS && cycles < POOL_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_free_cnt != `LMA_CELLS) begin
            report_failure("timeout waiting for the pool to be completely free");
            aborted = 1'b1;
        end
    endtask

    task automatic run_one(input int len, input int pause, input int exp_pass,
                           input int exp_count);
        int cycles;
        int pause_left;
        int errs_before;
        bit done_seen;
        bit running_lost;
        errs_before  = errors;
        cycles       = 0;
        pause_left   = 0;
        done_seen    = 1'b0;
        running_lost = 1'b0;
        tests++;
        // one-cycle start pulse
        @(posedge i_clk);
        i_len   <= len[`LMA_LEN_W-1:0];
        i_en    <= 1'b1;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        while (!done_seen && !aborted) begin
            @(negedge i_clk);
            if (o_done) begin
                done_seen = 1'b1;
            end else if (cycles >= RUN_TIMEOUT) begin
                report_failure("timeout waiting for o_done");
                aborted = 1'b1;
            end else begin
                cycles++;
                // must stay high until done even while i_en is paused
                if (!o_running && !running_lost) begin
                    report_failure("o_running dropped before o_done");
                    running_lost = 1'b1;
                end
                if (pause_left > 0) begin
                    pause_left--;
                end else if (pause != 0 && ($urandom % 8) == 0) begin
                    pause_left = 2 + ($urandom % 11);
                end
                @(posedge i_clk);
                i_en <= (pause_left == 0);
            end
        end
        if (done_seen) begin
            // results at the done pulse
            if (o_pass !== exp_pass[0]) begin
                report_mismatch("o_pass", exp_pass, o_pass);
            end
            if (o_count !== exp_count[`LMA_LEN_W-1:0]) begin
                report_mismatch("o_count", exp_count, o_count);
            end
            if (o_running !== 1'b0) begin
                report_mismatch("o_running", 0, o_running);
            end
            @(posedge i_clk);
            i_en <= 1'b1;
            @(negedge i_clk);
            // done lasts a single cycle
            if (o_done !== 1'b0) begin
                report_mismatch("o_done", 0, o_done);
            end
            wait_pool_full();
            // results hold until the next start
            if (o_pass !== exp_pass[0]) begin
                report_mismatch("o_pass (held)", exp_pass, o_pass);
            end
            if (o_count !== exp_count[`LMA_LEN_W-1:0]) begin
                report_mismatch("o_count (held)", exp_count, o_count);
            end
        end
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %0d: len %0d pause %0d pass %0b count %0d in %0d cycles, %s",
                 tests, len, pause, o_pass, o_count, cycles,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int fd;
        int n;
        int seed_val;
        int len_v;
        int pause_v;
        int pass_v;
        int count_v;
        int rule_count;
        int rule_pass;
        string line;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_en         = 1'b1;
        i_len        = '0;
        seed_val     = 32'h6450_cb2f;
        void'($urandom(seed_val));
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;
        // idle outputs straight out of reset
        @(negedge i_clk);
        tests++;
        if (o_running !== 1'b0) begin
            report_mismatch("o_running", 0, o_running);
        end
        if (o_done !== 1'b0) begin
            report_mismatch("o_done", 0, o_done);
        end
        if (o_pass !== 1'b0) begin
            report_mismatch("o_pass", 0, o_pass);
        end
        if (o_count !== '0) begin
            report_mismatch("o_count", 0, o_count);
        end
        wait_pool_full();
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test %0d: reset and sweep, %s", tests, (errors == 0) ? "ok" : "FAILED");
        if (!aborted) begin
            fd = $fopen("dv/lma_input.txt", "r");
            if (fd == 0) begin
                report_failure("cannot open dv/lma_input.txt");
            end else begin
                while (!$feof(fd) && !aborted) begin
                    n = $fgets(line, fd);
                    if (n != 0) begin
                        n = $sscanf(line, "%d %d %d %d", len_v, pause_v, pass_v, count_v);
                        // comment and blank lines do not scan
                        if (n == 4) begin
                            rule_count = (len_v < `LMA_CELLS) ? len_v : `LMA_CELLS;
                            rule_pass  = (len_v <= `LMA_CELLS) ? 1 : 0;
                            if (rule_count != count_v || rule_pass != pass_v) begin
                                report_failure($sformatf(
                                    "input line for length %0d disagrees with the length rule",
                                    len_v));
                            end
                            run_one(len_v, pause_v, rule_pass, rule_count);
                        end
                    end
                end
                $fclose(fd);
            end
        end
        finish_sim();
    end

endmodule

// File: include/lma_config.svh
/*
 * linked-memory allocator configuration
 * pool geometry, end-of-list marker, command FIFO depth and self-test length width
 */

`ifndef LMA_CONFIG_SVH
`define LMA_CONFIG_SVH

// pool of single-word cells
`define LMA_CELLS       16
`define LMA_ADDR_W      4
`define LMA_WORD_W      16

// end-of-list marker, never a valid cell address
`define LMA_NIL         16'hFFFF

// command buffering and requested run length
`define LMA_FIFO_DEPTH  4
`define LMA_LEN_W       8

`endif

// File: rtl/lma_cell_alloc.sv
/*
 * lma cell allocator
 * pool of one-word cells with the free list threaded through the free cells
 * sweeps every cell onto the free list after reset, then runs
 * ALLOC, READ and FREE with one response cycle
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_cell_alloc
    import lma_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_cmd_valid,
    input  lma_op_e                i_cmd_op,
    input  logic [`LMA_WORD_W-1:0] i_cmd_word,
    output logic                   o_cmd_ready,
    output logic                   o_rsp_valid,
    output logic [`LMA_WORD_W-1:0] o_rsp_word,
    output logic                   o_rsp_err,
    output logic [`LMA_ADDR_W:0]   o_free_cnt
);
    localparam int A_W = `LMA_ADDR_W;
    localparam int W_W = `LMA_WORD_W;

    logic [W_W-1:0] cells [`LMA_CELLS];
    // free-list head, NIL when the pool is exhausted
    logic [W_W-1:0] head;
    logic [A_W:0]   sweep_idx;
    logic           sweeping;
    logic [A_W-1:0] head_idx;
    logic [A_W-1:0] cmd_idx;
    logic           pool_empty;
    logic           addr_ok;
    logic           accept;
    logic           alloc_ok;
    logic           read_ok;
    logic           free_ok;
    logic           cmd_err;

    assign sweeping    = (sweep_idx != (A_W+1)'(`LMA_CELLS));
    assign o_cmd_ready = !sweeping;

    assign head_idx   = head[A_W-1:0];
    assign cmd_idx    = i_cmd_word[A_W-1:0];
    assign pool_empty = (head == `LMA_NIL);
    assign addr_ok    = (i_cmd_word < `LMA_CELLS);

    // command decode
    assign accept   = i_cmd_valid && o_cmd_ready;
    assign alloc_ok = accept && (i_cmd_op == OP_ALLOC) && !pool_empty;
    assign read_ok  = accept && (i_cmd_op == OP_READ) && addr_ok;
    assign free_ok  = accept && (i_cmd_op == OP_FREE) && addr_ok;
    // empty pool on alloc, out-of-range address otherwise
    assign cmd_err  = accept && ((i_cmd_op == OP_ALLOC) ? pool_empty : !addr_ok);

    // cell array, single write port
    always_ff @(posedge i_clk) begin
        if (sweeping) begin
            // push cell onto the list, first one inherits NIL
            cells[sweep_idx[A_W-1:0]] <= head;
        end else if (alloc_ok) begin
            cells[head_idx] <= i_cmd_word;
        end else if (free_ok) begin
            // freed cell points at the old head
            cells[cmd_idx] <= head;
        end
    end

    // free-list head, sweep and response control
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sweep_idx   <= '0;
            head        <= `LMA_NIL;
            o_free_cnt  <= '0;
            o_rsp_valid <= 1'b0;
            o_rsp_err   <= 1'b0;
        end else begin
            // free answers only when it fails
            o_rsp_valid <= accept && ((i_cmd_op != OP_FREE) || cmd_err);
            o_rsp_err   <= cmd_err;
            if (sweeping) begin
                head       <= {{(W_W-A_W){1'b0}}, sweep_idx[A_W-1:0]};
                sweep_idx  <= sweep_idx + 1'b1;
                o_free_cnt <= o_free_cnt + 1'b1;
            end else if (alloc_ok) begin
                // pop: next free cell is linked from the old head
                head       <= cells[head_idx];
                o_free_cnt <= o_free_cnt - 1'b1;
            end else if (free_ok) begin
                head       <= i_cmd_word;
                o_free_cnt <= o_free_cnt + 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge i_clk) begin
        if (alloc_ok) begin
            o_rsp_word <= head;
        end else if (read_ok) begin
            o_rsp_word <= cells[cmd_idx];
        end else if (accept) begin
            // errors echo the offending word
            o_rsp_word <= i_cmd_word;
        end
    end

endmodule

// File: rtl/lma_cmd_fifo.sv
/*
 * lma command FIFO
 * circular buffer between self-test and allocator, valid/ready on both sides
 * a written entry shows at the output on the following cycle
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_cmd_fifo
    import lma_pkg::*;
#(
    parameter int DEPTH = `LMA_FIFO_DEPTH
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_in_valid,
    input  lma_op_e                i_in_op,
    input  logic [`LMA_WORD_W-1:0] i_in_word,
    output logic                   o_in_ready,
    output logic                   o_out_valid,
    output lma_op_e                o_out_op,
    output logic [`LMA_WORD_W-1:0] o_out_word,
    input  logic                   i_out_ready
);
    localparam int PTR_W = $clog2(DEPTH);

    lma_op_e                op_mem [DEPTH];
    logic [`LMA_WORD_W-1:0] word_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   do_wr;
    logic                   do_rd;

    // full still accepts when the head leaves in the same cycle
    assign o_in_ready  = (count != (PTR_W+1)'(DEPTH)) || i_out_ready;
    assign o_out_valid = (count != '0);
    assign o_out_op    = op_mem[rd_ptr];
    assign o_out_word  = word_mem[rd_ptr];

    assign do_wr = i_in_valid && o_in_ready;
    assign do_rd = o_out_valid && i_out_ready;

    // storage
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            op_mem[wr_ptr]   <= i_in_op;
            word_mem[wr_ptr] <= i_in_word;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/lma_pkg.sv
/*
 * linked-memory allocator types
 * allocator opcodes and self-test sequencer states
 */

package lma_pkg;

    // allocator command opcodes
    typedef enum logic [1:0] {
        OP_ALLOC,
        OP_READ,
        OP_FREE
    } lma_op_e;

    // self-test phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUILD,
        ST_WALK,
        ST_DONE
    } lma_st_e;

endpackage

// File: rtl/lma_self_test.sv
/*
 * lma self-test sequencer
 * builds a linked list of the requested length through the allocator,
 * then walks it to NIL freeing each cell, and reports pass or fail
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_self_test
    import lma_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  logic                   i_en,
    input  logic [`LMA_LEN_W-1:0]  i_len,
    output logic                   o_cmd_valid,
    output lma_op_e                o_cmd_op,
    output logic [`LMA_WORD_W-1:0] o_cmd_word,
    input  logic                   i_cmd_ready,
    input  logic                   i_rsp_valid,
    input  logic [`LMA_WORD_W-1:0] i_rsp_word,
    input  logic                   i_rsp_err,
    output logic                   o_running,
    output logic                   o_done,
    output logic                   o_pass,
    output logic [`LMA_LEN_W-1:0]  o_count
);
    lma_st_e                state;
    logic [`LMA_LEN_W-1:0]  len_q;
    logic [`LMA_LEN_W-1:0]  build_cnt;
    // last allocated cell while building, next cell to visit while walking
    logic [`LMA_WORD_W-1:0] addr_q;
    logic                   wait_rsp;
    logic                   free_pend;
    logic                   err_seen;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            len_q       <= '0;
            build_cnt   <= '0;
            addr_q      <= `LMA_NIL;
            wait_rsp    <= 1'b0;
            free_pend   <= 1'b0;
            err_seen    <= 1'b0;
            o_cmd_valid <= 1'b0;
            o_cmd_op    <= OP_ALLOC;
            o_cmd_word  <= '0;
            o_running   <= 1'b0;
            o_done      <= 1'b0;
            o_pass      <= 1'b0;
            o_count     <= '0;
        end else begin
            o_done <= 1'b0;
            if (o_cmd_valid && i_cmd_ready) begin
                o_cmd_valid <= 1'b0;
            end
            // any error response taints the run, free errors included
            if (i_rsp_valid && i_rsp_err) begin
                err_seen <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state     <= ST_BUILD;
                        len_q     <= i_len;
                        build_cnt <= '0;
                        addr_q    <= `LMA_NIL;
                        wait_rsp  <= 1'b0;
                        free_pend <= 1'b0;
                        err_seen  <= 1'b0;
                        o_running <= 1'b1;
                        o_pass    <= 1'b0;
                        o_count   <= '0;
                    end
                end
                ST_BUILD: begin
                    if (wait_rsp) begin
                        if (i_rsp_valid) begin
                            wait_rsp <= 1'b0;
                            if (i_rsp_err) begin
                                // pool exhausted, walk what was built
                                state <= ST_WALK;
                            end else begin
                                addr_q <= i_rsp_word;
                            end
                        end
                    end else if (!o_cmd_valid) begin
                        if (build_cnt == len_q) begin
                            state <= ST_WALK;
                        end else if (i_en) begin
                            // new cell links to the previous head
                            o_cmd_valid <= 1'b1;
                            o_cmd_op    <= OP_ALLOC;
                            o_cmd_word  <= addr_q;
                            build_cnt   <= build_cnt + 1'b1;
                            wait_rsp    <= 1'b1;
                        end
                    end
                end
                ST_WALK: begin
                    if (wait_rsp) begin
                        if (i_rsp_valid) begin
                            wait_rsp <= 1'b0;
                            if (i_rsp_err) begin
                                addr_q <= `LMA_NIL;
                            end else begin
                                // stage the free of the visited cell, then follow its link
                                o_cmd_op   <= OP_FREE;
                                o_cmd_word <= addr_q;
                                addr_q     <= i_rsp_word;
                                free_pend  <= 1'b1;
                            end
                        end
                    end else if (free_pend) begin
                        // posted without waiting for a response
                        if (!o_cmd_valid && i_en) begin
                            o_cmd_valid <= 1'b1;
                            free_pend   <= 1'b0;
                            o_count     <= o_count + 1'b1;
                        end
                    end else if (!o_cmd_valid) begin
                        if (addr_q == `LMA_NIL) begin
                            state     <= ST_DONE;
                            o_running <= 1'b0;
                            o_done    <= 1'b1;
                            o_pass    <= !err_seen && (o_count == len_q);
                        end else if (i_en) begin
                            o_cmd_valid <= 1'b1;
                            o_cmd_op    <= OP_READ;
                            o_cmd_word  <= addr_q;
                            wait_rsp    <= 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/lma_top.sv
/*
 * lma top level
 * self-test posts commands through the command FIFO into the cell allocator,
 * responses return straight from the allocator to the self-test
 */

`timescale 1ns/1ps
`include "lma_config.svh"

module lma_top
    import lma_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_en,
    input  logic [`LMA_LEN_W-1:0] i_len,
    output logic                  o_running,
    output logic                  o_done,
    output logic                  o_pass,
    output logic [`LMA_LEN_W-1:0] o_count,
    output logic [`LMA_ADDR_W:0]  o_free_cnt
);
    // self-test to FIFO
    logic                   st_valid;
    lma_op_e                st_op;
    logic [`LMA_WORD_W-1:0] st_word;
    logic                   st_ready;
    // FIFO to allocator
    logic                   al_valid;
    lma_op_e                al_op;
    logic [`LMA_WORD_W-1:0] al_word;
    logic                   al_ready;
    // allocator responses
    logic                   rsp_valid;
    logic [`LMA_WORD_W-1:0] rsp_word;
    logic                   rsp_err;

    lma_self_test u_self_test (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_en        (i_en),
        .i_len       (i_len),
        .o_cmd_valid (st_valid),
        .o_cmd_op    (st_op),
        .o_cmd_word  (st_word),
        .i_cmd_ready (st_ready),
        .i_rsp_valid (rsp_valid),
        .i_rsp_word  (rsp_word),
        .i_rsp_err   (rsp_err),
        .o_running   (o_running),
        .o_done      (o_done),
        .o_pass      (o_pass),
        .o_count     (o_count)
    );

    lma_cmd_fifo #(
        .DEPTH (`LMA_FIFO_DEPTH)
    ) u_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (st_valid),
        .i_in_op     (st_op),
        .i_in_word   (st_word),
        .o_in_ready  (st_ready),
        .o_out_valid (al_valid),
        .o_out_op    (al_op),
        .o_out_word  (al_word),
        .i_out_ready (al_ready)
    );

    lma_cell_alloc u_alloc (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (al_valid),
        .i_cmd_op    (al_op),
        .i_cmd_word  (al_word),
        .o_cmd_ready (al_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp_word  (rsp_word),
        .o_rsp_err   (rsp_err),
        .o_free_cnt  (o_free_cnt)
    );

endmodule

// File: sources.f
+incdir+include
rtl/lma_pkg.sv
rtl/lma_cmd_fifo.sv
rtl/lma_cell_alloc.sv
rtl/lma_self_test.sv
rtl/lma_top.sv
dv/lma_assertions.sv
dv/lma_tb.sv
